// File: flist.f
source/lpcPkg.sv
source/basicOps.sv
source/weightAz.sv
source/memArbiter.sv
source/scratchMemory.sv
source/lpcWeighting.sv
tests/lpcWeightingChecker.sv
tests/lpcWeightingTb.sv

// File: Bender.yml
package:
  name: lpc_weighting

sources:
  - source/lpcPkg.sv
  - source/basicOps.sv
  - source/weightAz.sv
  - source/memArbiter.sv
  - source/scratchMemory.sv
  - source/lpcWeighting.sv
  - target: test
    files:
      - tests/lpcWeightingChecker.sv
      - tests/lpcWeightingTb.sv

// File: tests/lpcWeightingTb.sv
`timescale 1ns/1ns

module lpcWeightingTb;
	import lpcPkg::*;

	localparam int numTests = 9;
	localparam int waitLimit = 200;
	localparam int fixedSet = 0;
	localparam int satSet = 1;
	localparam int randomSet = 2;
	localparam logic [addrWidth-1:0] apOffset = 11'h020;
	localparam logic [addrWidth-1:0] denOffset = 11'h400;

	logic clk;
	logic reset;
	logic numValid;
	logic numReady;
	logic [addrWidth-1:0] numA;
	logic [addrWidth-1:0] numAp;
	logic [addrWidth-1:0] numGamma;
	logic numDone;
	logic denValid;
	logic denReady;
	logic [addrWidth-1:0] denA;
	logic [addrWidth-1:0] denAp;
	logic [addrWidth-1:0] denGamma;
	logic denDone;
	logic hostValid;
	logic hostReady;
	logic hostWrite;
	logic [addrWidth-1:0] hostAddr;
	logic [dataWidth-1:0] hostWData;
	logic [dataWidth-1:0] hostRData;
	logic hostRValid;

	// Test table with one entry per row
	string rowName [numTests];
	logic [1:0] rowLaunch [numTests];
	int rowKind [numTests];
	logic rowOverlap [numTests];
	logic [addrWidth-1:0] rowABase [numTests];
	logic [addrWidth-1:0] rowGammaAddr [numTests];
	logic signed [dataWidth-1:0] rowNumGamma [numTests];
	logic signed [dataWidth-1:0] rowDenGamma [numTests];

	logic signed [dataWidth-1:0] coefNum [lpcOrder+1];
	logic signed [dataWidth-1:0] coefDen [lpcOrder+1];
	int stallCycles;
	int t;

	lpcWeighting dut_i
	(
		.clk(clk),
		.reset(reset),
		.numValid(numValid),
		.numReady(numReady),
		.numA(numA),
		.numAp(numAp),
		.numGamma(numGamma),
		.numDone(numDone),
		.denValid(denValid),
		.denReady(denReady),
		.denA(denA),
		.denAp(denAp),
		.denGamma(denGamma),
		.denDone(denDone),
		.hostValid(hostValid),
		.hostReady(hostReady),
		.hostWrite(hostWrite),
		.hostAddr(hostAddr),
		.hostWData(hostWData),
		.hostRData(hostRData),
		.hostRValid(hostRValid)
	);

	lpcWeightingChecker checker_i
	(
		.clk(clk),
		.hostRValid(hostRValid),
		.hostRData(hostRData),
		.numDone(numDone),
		.denDone(denDone)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////
	// Reference model
	////////////////////

	// Doubled product where only -1 times -1 leaves the Q31 range
	function automatic logic signed [31:0] fracMult(input logic signed [15:0] a,
		input logic signed [15:0] b);
		logic signed [31:0] p;
		if (a == 16'sh8000 && b == 16'sh8000)
			return 32'sh7FFF_FFFF;
		p = a * b;
		return p * 2;
	endfunction

	function automatic logic signed [15:0] roundHigh(input logic signed [31:0] x);
		longint s;
		s = longint'(x) + 32768;
		if (s > 64'sh7FFF_FFFF)
			s = 64'sh7FFF_FFFF;
		return s[31:16];
	endfunction

	// ap[i] = a[i] * gamma^i with the power built one rounded step at a time
	function automatic logic signed [15:0] expectedWord(input logic signed [15:0] coef,
		input logic signed [15:0] g, input int i);
		logic signed [15:0] fac;
		if (i == 0)
			return coef;
		fac = g;
		for (int k = 1; k < i; k++)
			fac = roundHigh(fracMult(fac, g));
		return roundHigh(fracMult(coef, fac));
	endfunction

	function automatic logic signed [15:0] fixedCoef(input int i);
		case (i)
			0: return 16'sd4096;
			1: return -16'sd7421;
			2: return 16'sd6310;
			3: return -16'sd4822;
			4: return 16'sd3355;
			5: return -16'sd2107;
			6: return 16'sd1480;
			7: return -16'sd903;
			8: return 16'sd544;
			9: return -16'sd261;
			default: return 16'sd120;
		endcase
	endfunction

	task automatic defineRow(input int idx, input string name, input logic [1:0] launch,
		input int kind, input logic overlap, input logic [addrWidth-1:0] aBase,
		input logic [15:0] gNum, input logic [15:0] gDen);
		rowName[idx] = name;
		rowLaunch[idx] = launch;
		rowKind[idx] = kind;
		rowOverlap[idx] = overlap;
		rowABase[idx] = aBase;
		rowGammaAddr[idx] = 11'h7C0 + addrWidth'(2 * idx);
		rowNumGamma[idx] = gNum;
		rowDenGamma[idx] = gDen;
	endtask

	task automatic fillCoefs(input int row);
		for (int i = 0; i <= lpcOrder; i++)
		begin
			case (rowKind[row])
				fixedSet:
				begin
					coefNum[i] = fixedCoef(i);
					coefDen[i] = fixedCoef(lpcOrder - i);
				end
				satSet:
				begin
					coefNum[i] = (i % 2 == 1) ? 16'sh7FFF : 16'sh8000;
					coefDen[i] = (i % 2 == 1) ? 16'sh8000 : 16'sh7FFF;
				end
				default:
				begin
					coefNum[i] = 16'($urandom);
					coefDen[i] = 16'($urandom);
				end
			endcase
		end
	endtask

	////////////////////
	// Bus and job drivers
	////////////////////

	// One host word that returns on the edge where it was taken
	task automatic hostTransfer(input logic write, input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] data);
		int count;
		logic granted;
		hostValid <= 1'b1;
		hostWrite <= write;
		hostAddr <= addr;
		hostWData <= data;
		count = 0;
		granted = 1'b0;
		while (!granted && count < waitLimit)
		begin
			@(posedge clk);
			count++;
			granted = hostReady;
			if (!granted)
				stallCycles++;
		end
		if (!granted)
			checker_i.reportProblem("timed out waiting for hostReady");
	endtask

	task automatic releaseBus();
		hostValid <= 1'b0;
		hostWrite <= 1'b0;
	endtask

	task automatic loadVector(input logic den, input int row);
		logic [addrWidth-1:0] base;
		base = rowABase[row] + (den ? denOffset : 11'h000);
		for (int i = 0; i <= lpcOrder; i++)
			hostTransfer(1'b1, base + addrWidth'(i), den ? coefDen[i] : coefNum[i]);
		hostTransfer(1'b1, rowGammaAddr[row] + addrWidth'(den),
			den ? rowDenGamma[row] : rowNumGamma[row]);
	endtask

	task automatic readBack(input logic den, input int row);
		logic [addrWidth-1:0] base;
		logic signed [dataWidth-1:0] g;
		base = rowABase[row] + apOffset + (den ? denOffset : 11'h000);
		g = den ? rowDenGamma[row] : rowNumGamma[row];
		for (int i = 0; i <= lpcOrder; i++)
			checker_i.expectWord(expectedWord(den ? coefDen[i] : coefNum[i], g, i));
		for (int i = 0; i <= lpcOrder; i++)
			hostTransfer(1'b0, base + addrWidth'(i), '0);
		releaseBus();
	endtask

	task automatic launchJobs(input int row);
		int count;
		logic pendNum;
		logic pendDen;
		numA <= rowABase[row];
		numAp <= rowABase[row] + apOffset;
		numGamma <= rowGammaAddr[row];
		denA <= rowABase[row] + denOffset;
		denAp <= rowABase[row] + denOffset + apOffset;
		denGamma <= rowGammaAddr[row] + 11'd1;
		pendNum = rowLaunch[row][0];
		pendDen = rowLaunch[row][1];
		numValid <= pendNum;
		denValid <= pendDen;
		count = 0;
		while ((pendNum || pendDen) && count < waitLimit)
		begin
			@(posedge clk);
			count++;
			if (pendNum && numReady)
			begin
				pendNum = 1'b0;
				numValid <= 1'b0;
			end
			if (pendDen && denReady)
			begin
				pendDen = 1'b0;
				denValid <= 1'b0;
			end
		end
		if (pendNum || pendDen)
			checker_i.reportProblem("timed out waiting for a job to be accepted");
	endtask

	task automatic waitDone(input int row);
		int count;
		logic waiting;
		count = 0;
		waiting = (rowLaunch[row][0] && checker_i.numDoneCount == 0) ||
			(rowLaunch[row][1] && checker_i.denDoneCount == 0);
		while (waiting && count < waitLimit)
		begin
			@(posedge clk);
			count++;
			waiting = (rowLaunch[row][0] && checker_i.numDoneCount == 0) ||
				(rowLaunch[row][1] && checker_i.denDoneCount == 0);
		end
		if (waiting)
			checker_i.reportProblem("timed out waiting for the done pulse");
	endtask

	task automatic waitDrained();
		int count;
		count = 0;
		while (checker_i.pendingWords() > 0 && count < waitLimit)
		begin
			@(posedge clk);
			count++;
		end
	endtask

	initial
	begin
		void'($urandom(8));
		reset = 1'b1;
		numValid = 1'b0;
		numA = '0;
		numAp = '0;
		numGamma = '0;
		denValid = 1'b0;
		denA = '0;
		denAp = '0;
		denGamma = '0;
		hostValid = 1'b0;
		hostWrite = 1'b0;
		hostAddr = '0;
		hostWData = '0;
		stallCycles = 0;

		defineRow(0, "resetIdle", 2'b00, fixedSet, 1'b0, 11'h000, 16'h0000, 16'h0000);
		defineRow(1, "numFixed", 2'b01, fixedSet, 1'b0, 11'h040, 16'h7333, 16'h0000);
		defineRow(2, "satGammaMax", 2'b01, satSet, 1'b0, 11'h080, 16'h7FFF, 16'h0000);
		defineRow(3, "satGammaMin", 2'b10, satSet, 1'b0, 11'h0C0, 16'h0000, 16'h8000);
		defineRow(4, "bothEngines", 2'b11, fixedSet, 1'b0, 11'h100, 16'h7333, 16'h599A);
		defineRow(5, "hostBackPressure", 2'b01, fixedSet, 1'b1, 11'h140, 16'h6666, 16'h0000);
		defineRow(6, "randomNum", 2'b01, randomSet, 1'b0, 11'h180, 16'h7AE1, 16'h0000);
		defineRow(7, "randomBoth", 2'b11, randomSet, 1'b0, 11'h1C0, 16'h7333, 16'h4CCD);
		defineRow(8, "randomDen", 2'b10, randomSet, 1'b0, 11'h200, 16'h0000, 16'h7FFF);

		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		for (t = 0; t < numTests; t++)
		begin
			checker_i.startTest(rowName[t]);
			if (rowLaunch[t] == 2'b00)
			begin
				// Idle engines give no done pulse without a job
				checker_i.checkBit("numReady after reset", 1'b1, numReady);
				checker_i.checkBit("denReady after reset", 1'b1, denReady);
				repeat (8) @(posedge clk);
			end
			else
			begin
				fillCoefs(t);
				if (rowLaunch[t][0])
					loadVector(1'b0, t);
				if (rowLaunch[t][1])
					loadVector(1'b1, t);
				releaseBus();
				launchJobs(t);
				if (rowOverlap[t])
				begin
					// Engine owns the bus before the host asks
					@(posedge clk);
					stallCycles = 0;
					readBack(1'b0, t);
					checker_i.checkBit("host held off by engine", 1'b1, stallCycles > 4);
				end
				waitDone(t);
				if (!rowOverlap[t] && rowLaunch[t][0])
					readBack(1'b0, t);
				if (!rowOverlap[t] && rowLaunch[t][1])
					readBack(1'b1, t);
				waitDrained();
			end
			checker_i.finishTest(rowLaunch[t][0], rowLaunch[t][1]);
		end

		checker_i.printSummary();
		if (checker_i.failCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: tests/lpcWeightingChecker.sv
`timescale 1ns/1ns

module lpcWeightingChecker
(
	input logic                         clk,
	input logic                         hostRValid,
	input logic [lpcPkg::dataWidth-1:0] hostRData,
	input logic                         numDone,
	input logic                         denDone
);
	import lpcPkg::*;

	string testName = "none";
	logic [dataWidth-1:0] expectQ [$];
	logic [dataWidth-1:0] expWord;
	int wordIndex = 0;
	int numDoneCount = 0;
	int denDoneCount = 0;
	int testErrors = 0;
	int passCount = 0;
	int failCount = 0;

	// Done pulses and read-back data, sampled on the rising edge
	always @(posedge clk)
	begin
		if (numDone)
			numDoneCount++;
		if (denDone)
			denDoneCount++;
		if (hostRValid)
		begin
			if (expectQ.size() == 0)
			begin
				$display("%s: read data came back with no word expected", testName);
				testErrors++;
			end
			else
			begin
				expWord = expectQ.pop_front();
				if (hostRData !== expWord)
				begin
					$display("Fail %s word %0d: expected 0x%h, actual 0x%h",
						testName, wordIndex, expWord, hostRData);
					testErrors++;
				end
				wordIndex++;
			end
		end
	end

	////////////////////
	// Calls from the testbench
	////////////////////

	task automatic startTest(input string name);
		testName = name;
		wordIndex = 0;
		numDoneCount = 0;
		denDoneCount = 0;
		testErrors = 0;
		expectQ.delete();
	endtask

	task automatic expectWord(input logic [dataWidth-1:0] word);
		expectQ.push_back(word);
	endtask

	function automatic int pendingWords();
		return expectQ.size();
	endfunction

	task automatic checkBit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("Fail %s %s: expected %0d, actual %0d", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic reportProblem(input string what);
		$display("%s: %s", testName, what);
		testErrors++;
	endtask

	task automatic finishTest(input int expNum, input int expDen);
		if (numDoneCount != expNum)
		begin
			$display("Fail %s numDone pulses: expected %0d, actual %0d",
				testName, expNum, numDoneCount);
			testErrors++;
		end
		if (denDoneCount != expDen)
		begin
			$display("Fail %s denDone pulses: expected %0d, actual %0d",
				testName, expDen, denDoneCount);
			testErrors++;
		end
		if (expectQ.size() != 0)
		begin
			$display("%s: %0d read words never came back", testName, expectQ.size());
			testErrors++;
			expectQ.delete();
		end
		if (testErrors == 0)
		begin
			passCount++;
			$display("Test %s passed", testName);
		end
		else
		begin
			failCount++;
			$display("Test %s failed with %0d errors", testName, testErrors);
		end
	endtask

	task automatic printSummary();
		$display("%0d tests run, %0d passed, %0d failed",
			passCount + failCount, passCount, failCount);
	endtask

endmodule

// File: source/lpcWeighting.sv
`timescale 1ns/1ns

module lpcWeighting
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         numValid,
	output logic                         numReady,
	input  logic [lpcPkg::addrWidth-1:0] numA,
	input  logic [lpcPkg::addrWidth-1:0] numAp,
	input  logic [lpcPkg::addrWidth-1:0] numGamma,
	output logic                         numDone,
	input  logic                         denValid,
	output logic                         denReady,
	input  logic [lpcPkg::addrWidth-1:0] denA,
	input  logic [lpcPkg::addrWidth-1:0] denAp,
	input  logic [lpcPkg::addrWidth-1:0] denGamma,
	output logic                         denDone,
	input  logic                         hostValid,
	output logic                         hostReady,
	input  logic                         hostWrite,
	input  logic [lpcPkg::addrWidth-1:0] hostAddr,
	input  logic [lpcPkg::dataWidth-1:0] hostWData,
	output logic [lpcPkg::dataWidth-1:0] hostRData,
	output logic                         hostRValid
);
	import lpcPkg::*;

	wire [numPeers-1:0] req;
	wire [numPeers-1:0] grant;
	wire [numPeers-1:0][addrWidth-1:0] peerRdAddr;
	wire [numPeers-1:0][addrWidth-1:0] peerWrAddr;
	wire [numPeers-1:0][dataWidth-1:0] peerWrData;
	wire [numPeers-1:0] peerWrEn;

	logic [addrWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWrData;
	logic memWrEn;
	logic [dataWidth-1:0] memRdData;

	////////////////////
	// Host peer
	////////////////////

	assign req[peerHost] = hostValid;
	assign peerRdAddr[peerHost] = hostAddr;
	assign peerWrAddr[peerHost] = hostAddr;
	assign peerWrData[peerHost] = hostWData;
	assign peerWrEn[peerHost] = hostValid && hostWrite;
	assign hostReady = grant[peerHost];
	assign hostRData = memRdData;

	////////////////////
	// Weighting engines
	////////////////////

	weightAz numWeight_i
	(
		.clk(clk),
		.reset(reset),
		.jobValid(numValid),
		.jobReady(numReady),
		.coefBase(numA),
		.weightBase(numAp),
		.gammaAddr(numGamma),
		.done(numDone),
		.busReq(req[peerNum]),
		.busGrant(grant[peerNum]),
		.rdAddr(peerRdAddr[peerNum]),
		.wrAddr(peerWrAddr[peerNum]),
		.wrData(peerWrData[peerNum]),
		.wrEn(peerWrEn[peerNum]),
		.rdData(memRdData)
	);

	weightAz denWeight_i
	(
		.clk(clk),
		.reset(reset),
		.jobValid(denValid),
		.jobReady(denReady),
		.coefBase(denA),
		.weightBase(denAp),
		.gammaAddr(denGamma),
		.done(denDone),
		.busReq(req[peerDen]),
		.busGrant(grant[peerDen]),
		.rdAddr(peerRdAddr[peerDen]),
		.wrAddr(peerWrAddr[peerDen]),
		.wrData(peerWrData[peerDen]),
		.wrEn(peerWrEn[peerDen]),
		.rdData(memRdData)
	);

	memArbiter memArbiter_i
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.grant(grant),
		.peerRdAddr(peerRdAddr),
		.peerWrAddr(peerWrAddr),
		.peerWrData(peerWrData),
		.peerWrEn(peerWrEn),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWrEn(memWrEn),
		.hostRdValid(hostRValid)
	);

	scratchMemory scratchMemory_i
	(
		.clk(clk),
		.addr(memAddr),
		.wrData(memWrData),
		.wrEn(memWrEn),
		.rdData(memRdData)
	);

endmodule

// File: source/scratchMemory.sv
`timescale 1ns/1ns

module scratchMemory
(
	input  logic                         clk,
	input  logic [lpcPkg::addrWidth-1:0] addr,
	input  logic [lpcPkg::dataWidth-1:0] wrData,
	input  logic                         wrEn,
	output logic [lpcPkg::dataWidth-1:0] rdData
);
	import lpcPkg::*;

	logic [dataWidth-1:0] mem [memDepth];

	// Read-first, data valid one cycle after the address
	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[addr] <= wrData;
		rdData <= mem[addr];
	end

endmodule

// File: source/memArbiter.sv
`timescale 1ns/1ns

module memArbiter
(
	input  logic                                                clk,
	input  logic                                                reset,
	input  logic [lpcPkg::numPeers-1:0]                         req,
	output logic [lpcPkg::numPeers-1:0]                         grant,
	input  logic [lpcPkg::numPeers-1:0][lpcPkg::addrWidth-1:0] peerRdAddr,
	input  logic [lpcPkg::numPeers-1:0][lpcPkg::addrWidth-1:0] peerWrAddr,
	input  logic [lpcPkg::numPeers-1:0][lpcPkg::dataWidth-1:0] peerWrData,
	input  logic [lpcPkg::numPeers-1:0]                         peerWrEn,
	output logic [lpcPkg::addrWidth-1:0]                        memAddr,
	output logic [lpcPkg::dataWidth-1:0]                        memWrData,
	output logic                                                memWrEn,
	output logic                                                hostRdValid
);
	import lpcPkg::*;

	// Owner also serves as round-robin pointer once released
	logic [peerWidth-1:0] owner;
	logic ownerValid;
	logic [peerWidth-1:0] pickOwner;
	logic pickValid;
	logic holdOwner;

	assign holdOwner = ownerValid && req[owner];

	// First requester after the last owner
	always_comb
	begin
		int idx;
		pickValid = 1'b0;
		pickOwner = owner;
		for (int step = 1; step <= numPeers; step++)
		begin
			idx = int'(owner) + step;
			if (idx >= numPeers)
				idx = idx - numPeers;
			if (!pickValid && req[idx])
			begin
				pickValid = 1'b1;
				pickOwner = peerWidth'(idx);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ownerValid <= 1'b0;
			owner <= peerWidth'(peerHost);
			hostRdValid <= 1'b0;
		end
		else
		begin
			if (!holdOwner)
			begin
				ownerValid <= pickValid;
				owner <= pickOwner;
			end
			// Pairs with the one-cycle RAM read
			hostRdValid <= ownerValid && (owner == peerWidth'(peerHost)) &&
				req[peerHost] && !peerWrEn[peerHost];
		end
	end

	always_comb
	begin
		grant = '0;
		memAddr = '0;
		memWrData = '0;
		memWrEn = 1'b0;
		if (ownerValid)
		begin
			grant[owner] = 1'b1;
			// Write address wins the single port
			memAddr = peerWrEn[owner] ? peerWrAddr[owner] : peerRdAddr[owner];
			memWrData = peerWrData[owner];
			memWrEn = peerWrEn[owner];
		end
	end

endmodule

// File: source/weightAz.sv
`timescale 1ns/1ns

module weightAz
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         jobValid,
	output logic                         jobReady,
	input  logic [lpcPkg::addrWidth-1:0] coefBase,
	input  logic [lpcPkg::addrWidth-1:0] weightBase,
	input  logic [lpcPkg::addrWidth-1:0] gammaAddr,
	output logic                         done,
	output logic                         busReq,
	input  logic                         busGrant,
	output logic [lpcPkg::addrWidth-1:0] rdAddr,
	output logic [lpcPkg::addrWidth-1:0] wrAddr,
	output logic [lpcPkg::dataWidth-1:0] wrData,
	output logic                         wrEn,
	input  logic [lpcPkg::dataWidth-1:0] rdData
);
	import lpcPkg::*;

	weightState state;
	weightState nextState;

	logic [addrWidth-1:0] coefBaseQ;
	logic [addrWidth-1:0] weightBaseQ;
	logic [addrWidth-1:0] gammaAddrQ;

	logic signed [dataWidth-1:0] fac;
	logic signed [dataWidth-1:0] nextFac;
	logic signed [dataWidth-1:0] gamma;
	logic signed [dataWidth-1:0] nextGamma;
	logic signed [dataWidth-1:0] iter;
	logic signed [dataWidth-1:0] nextIter;
	logic accept;

	logic signed [15:0] multA;
	logic signed [15:0] multB;
	logic signed [31:0] multOut;
	logic signed [31:0] addA;
	logic signed [31:0] addB;
	logic signed [31:0] addOut;
	logic signed [15:0] incA;
	logic signed [15:0] incB;
	logic signed [15:0] incOut;

	assign jobReady = (state == idle) && !busReq;
	assign accept = jobValid && jobReady;

	basicOps basicOps_i
	(
		.multA(multA),
		.multB(multB),
		.multOut(multOut),
		.addA(addA),
		.addB(addB),
		.addOut(addOut),
		.incA(incA),
		.incB(incB),
		.incOut(incOut)
	);

	// Job bases held for the whole transaction
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			coefBaseQ <= coefBase;
			weightBaseQ <= weightBase;
			gammaAddrQ <= gammaAddr;
		end
	end

	// Request rises on acceptance, falls the cycle after lastCoef
	always_ff @(posedge clk)
	begin
		if (reset)
			busReq <= 1'b0;
		else if (accept)
			busReq <= 1'b1;
		else if (state == lastCoef)
			busReq <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			iter <= 16'sd1;
		end
		else
		begin
			state <= nextState;
			iter <= nextIter;
		end
	end

	always_ff @(posedge clk)
	begin
		fac <= nextFac;
		gamma <= nextGamma;
	end

	////////////////////
	// Engine FSM
	////////////////////

	always_comb
	begin
		nextState = state;
		nextFac = fac;
		nextGamma = gamma;
		nextIter = iter;
		rdAddr = '0;
		wrAddr = '0;
		wrData = '0;
		wrEn = 1'b0;
		done = 1'b0;
		multA = '0;
		multB = '0;
		addA = multOut;
		addB = roundConst;
		incA = iter;
		incB = 16'sd1;

		case (state)
			idle:
				// a[0] read goes out in the grant cycle
				if (busReq && busGrant)
				begin
					rdAddr = {coefBaseQ[addrWidth-1:4], 4'd0};
					nextState = copyFirst;
				end
			copyFirst:
			begin
				// Park a[0] in fac while gamma is fetched
				nextFac = rdData;
				rdAddr = gammaAddrQ;
				nextIter = 16'sd1;
				nextState = loadGamma;
			end
			loadGamma:
			begin
				wrAddr = {weightBaseQ[addrWidth-1:4], 4'd0};
				wrData = fac;
				wrEn = 1'b1;
				nextFac = rdData;
				nextGamma = rdData;
				nextState = loopHead;
			end
			loopHead:
				if (iter == 16'(lpcOrder))
				begin
					rdAddr = {coefBaseQ[addrWidth-1:4], 4'(lpcOrder)};
					nextState = lastCoef;
				end
				else
				begin
					rdAddr = {coefBaseQ[addrWidth-1:4], iter[3:0]};
					nextState = weightCoef;
				end
			weightCoef:
			begin
				// ap[i] = round(a[i] * fac)
				multA = rdData;
				multB = fac;
				wrAddr = {weightBaseQ[addrWidth-1:4], iter[3:0]};
				wrData = addOut[31:16];
				wrEn = 1'b1;
				nextState = stepFactor;
			end
			stepFactor:
			begin
				multA = fac;
				multB = gamma;
				nextFac = addOut[31:16];
				nextIter = incOut;
				nextState = loopHead;
			end
			lastCoef:
			begin
				multA = rdData;
				multB = fac;
				wrAddr = {weightBaseQ[addrWidth-1:4], 4'(lpcOrder)};
				wrData = addOut[31:16];
				wrEn = 1'b1;
				done = 1'b1;
				nextState = idle;
			end
			default:
				nextState = idle;
		endcase
	end

endmodule

// File: source/basicOps.sv
`timescale 1ns/1ns

module basicOps
(
	input  logic signed [15:0] multA,
	input  logic signed [15:0] multB,
	output logic signed [31:0] multOut,
	input  logic signed [31:0] addA,
	input  logic signed [31:0] addB,
	output logic signed [31:0] addOut,
	input  logic signed [15:0] incA,
	input  logic signed [15:0] incB,
	output logic signed [15:0] incOut
);
	import lpcPkg::*;

	logic signed [31:0] product;
	logic signed [32:0] sum32;
	logic signed [16:0] sum16;

	// Fractional multiply, product doubled
	always_comb
	begin
		product = multA * multB;
		// Only -1 * -1 overflows when doubled
		if (product == 32'sh4000_0000)
			multOut = q31Max;
		else
			multOut = product <<< 1;
	end

	// 32-bit saturating add
	always_comb
	begin
		sum32 = {addA[31], addA} + {addB[31], addB};
		if (sum32[32] != sum32[31])
			addOut = sum32[32] ? q31Min : q31Max;
		else
			addOut = sum32[31:0];
	end

	// 16-bit saturating add
	always_comb
	begin
		sum16 = {incA[15], incA} + {incB[15], incB};
		if (sum16[16] != sum16[15])
			incOut = sum16[16] ? q15Min : q15Max;
		else
			incOut = sum16[15:0];
	end

endmodule

// File: source/lpcPkg.sv
package lpcPkg;

	////////////////////
	// Scratch memory geometry
	////////////////////

	localparam int addrWidth = 11;
	localparam int dataWidth = 16;
	localparam int memDepth = 2048;

	// Filter order m
	localparam int lpcOrder = 10;

	////////////////////
	// Fixed-point constants
	////////////////////

	// Added to a Q31 value before taking the upper half
	localparam logic signed [31:0] roundConst = 32'sh0000_8000;

	localparam logic signed [15:0] q15Max = 16'sh7FFF;
	localparam logic signed [15:0] q15Min = 16'sh8000;
	localparam logic signed [31:0] q31Max = 32'sh7FFF_FFFF;
	localparam logic signed [31:0] q31Min = 32'sh8000_0000;

	////////////////////
	// Bus peers
	////////////////////

	localparam int numPeers = 3;
	localparam int peerWidth = $clog2(numPeers);
	localparam int peerNum = 0;
	localparam int peerDen = 1;
	localparam int peerHost = 2;

	// Weighting engine states
	typedef enum logic [2:0]
	{
		idle,
		copyFirst,
		loadGamma,
		loopHead,
		weightCoef,
		stepFactor,
		lastCoef
	} weightState;

endpackage
